/* src/dct_pkg.sv */
// Assumes 8-bit unsigned pixels and 16-point rows; fold sums reuse fold_t bits as unsigned values
package dct_pkg;

    // Row geometry
    localparam int N_POINTS    = 16;
    localparam int HALF_POINTS = N_POINTS / 2;

    // Bit widths that carry a meaning along the pipe
    localparam int PIXEL_W = 8;
    // Mirrored pair sum or difference
    localparam int FOLD_W  = PIXEL_W + 1;
    // Table magnitudes stay below 64
    localparam int COEF_W  = 7;
    // Worst case is 255 * 16 * 45, well inside 18 magnitude bits
    localparam int ACC_W   = 19;
    localparam int OUT_W   = 11;

    typedef logic [PIXEL_W-1:0]            pixel_t;
    // Pixel 0 sits in the top byte
    typedef logic [N_POINTS*PIXEL_W-1:0]   row_in_t;
    typedef logic signed [FOLD_W-1:0]      fold_t;
    typedef logic [COEF_W-1:0]             coef_t;
    typedef logic signed [ACC_W-1:0]       acc_t;
    typedef logic signed [OUT_W-1:0]       coef_out_t;
    // Coefficient 0 sits in the top field
    typedef logic [N_POINTS*OUT_W-1:0]     row_out_t;

    // Cosine magnitudes C_0 .. C_16, scaled so that C_0 = 32
    // C_16 closes the quarter period and is zero
    localparam coef_t DCT_COEF [N_POINTS+1] = '{
        7'd32, 7'd45, 7'd44, 7'd43,
        7'd42, 7'd40, 7'd38, 7'd35,
        7'd32, 7'd29, 7'd25, 7'd21,
        7'd17, 7'd13, 7'd9,  7'd4,
        7'd0
    };

endpackage

/* src/dct_fold_stage.sv */
// Registers mirrored pair sums and differences; sum lanes hold unsigned 0..510 in fold_t bits
`timescale 1ns/1ns

module dct_fold_stage import dct_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  row_in_t x_n_in,
    output fold_t   fold_sum  [HALF_POINTS],
    output fold_t   fold_diff [HALF_POINTS]
);

    // Pixel lanes in natural order
    pixel_t px [N_POINTS];

    // Next-state values for the two lane arrays
    fold_t  sum_nxt  [HALF_POINTS];
    fold_t  diff_nxt [HALF_POINTS];

    // Pixel 0 is the most significant byte of the row
    always_comb begin
        for (int n = 0; n < N_POINTS; n++) begin
            px[n] = x_n_in[(N_POINTS-1-n)*PIXEL_W +: PIXEL_W];
        end
    end

    // Lane i pairs pixel i with its mirror 15-i
    always_comb begin
        for (int i = 0; i < HALF_POINTS; i++) begin
            // Nine bits hold the full sum as an unsigned pattern
            sum_nxt[i]  = fold_t'({1'b0, px[i]} + {1'b0, px[N_POINTS-1-i]});
            // Difference stays within -255..255, so it is exact as signed
            diff_nxt[i] = fold_t'({1'b0, px[i]} - {1'b0, px[N_POINTS-1-i]});
        end
    end

    // First pipeline register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < HALF_POINTS; i++) begin
                fold_sum[i]  <= '0;
                fold_diff[i] <= '0;
            end
        end else begin
            for (int i = 0; i < HALF_POINTS; i++) begin
                fold_sum[i]  <= sum_nxt[i];
                fold_diff[i] <= diff_nxt[i];
            end
        end
    end

endmodule

/* src/dct_even_stage.sv */
// Even outputs 0,2,..,14 in that lane order; fold_sum lanes are read as unsigned values
`timescale 1ns/1ns

module dct_even_stage import dct_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  fold_t fold_sum [HALF_POINTS],
    output acc_t  even_acc [HALF_POINTS]
);

    localparam int QUARTER = HALF_POINTS / 2;

    // Fold sums widened to accumulator scale
    acc_t s  [HALF_POINTS];
    // Second butterfly on the fold sums
    acc_t ss [QUARTER];
    acc_t sd [QUARTER];
    // Third butterfly, only for outputs 0, 4, 8 and 12
    acc_t sss0;
    acc_t sss1;
    acc_t ssd0;
    acc_t ssd1;

    acc_t even_nxt [HALF_POINTS];

    // Table entry widened to the accumulator, always positive
    function automatic acc_t coef_of(input int idx);
        return acc_t'(DCT_COEF[idx]);
    endfunction

    always_comb begin
        // Zero extension keeps sums up to 510 positive
        for (int i = 0; i < HALF_POINTS; i++) begin
            s[i] = acc_t'($unsigned(fold_sum[i]));
        end

        // Pair lane i with lane 7-i
        for (int i = 0; i < QUARTER; i++) begin
            ss[i] = s[i] + s[HALF_POINTS-1-i];
            sd[i] = s[i] - s[HALF_POINTS-1-i];
        end

        sss0 = ss[0] + ss[3];
        sss1 = ss[1] + ss[2];
        ssd0 = ss[0] - ss[3];
        ssd1 = ss[1] - ss[2];

        // DC and the half-band term share C_0 = C_8
        even_nxt[0] = coef_of(0) * (sss0 + sss1);
        even_nxt[4] = coef_of(8) * (sss0 - sss1);

        // C_4 / C_12 rotation
        even_nxt[2] = coef_of(4) * ssd0 + coef_of(12) * ssd1;
        even_nxt[6] = coef_of(12) * ssd0 - coef_of(4) * ssd1;

        // Outputs 2, 6, 10, 14 from the second-level differences
        even_nxt[1] = coef_of(2) * sd[0] + coef_of(6) * sd[1]
                    + coef_of(10) * sd[2] + coef_of(14) * sd[3];
        even_nxt[3] = coef_of(6) * sd[0] - coef_of(14) * sd[1]
                    - coef_of(2) * sd[2] - coef_of(10) * sd[3];
        even_nxt[5] = coef_of(10) * sd[0] - coef_of(2) * sd[1]
                    + coef_of(14) * sd[2] + coef_of(6) * sd[3];
        even_nxt[7] = coef_of(14) * sd[0] - coef_of(10) * sd[1]
                    + coef_of(6) * sd[2] - coef_of(2) * sd[3];
    end

    // Second pipeline register, even half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < HALF_POINTS; j++) begin
                even_acc[j] <= '0;
            end
        end else begin
            for (int j = 0; j < HALF_POINTS; j++) begin
                even_acc[j] <= even_nxt[j];
            end
        end
    end

endmodule

/* src/dct_odd_stage.sv */
// Odd outputs 1,3,..,15 in that lane order; every entry is a constant folded at elaboration
`timescale 1ns/1ns

module dct_odd_stage import dct_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  fold_t fold_diff [HALF_POINTS],
    output acc_t  odd_acc   [HALF_POINTS]
);

    // One full cosine period in table steps
    localparam int PERIOD = 4 * N_POINTS;
    localparam int HALF_P = 2 * N_POINTS;

    acc_t odd_nxt [HALF_POINTS];

    // Signed matrix entry for output k and pixel n
    // Each quarter of the period picks a mirrored table index and a sign
    function automatic acc_t odd_entry(input int k, input int n);
        int m;
        m = (k * (2 * n + 1)) % PERIOD;
        if (m <= N_POINTS) begin
            return acc_t'(DCT_COEF[m]);
        end else if (m <= HALF_P) begin
            return -acc_t'(DCT_COEF[HALF_P - m]);
        end else if (m < HALF_P + N_POINTS) begin
            return -acc_t'(DCT_COEF[m - HALF_P]);
        end else begin
            return acc_t'(DCT_COEF[PERIOD - m]);
        end
    endfunction

    // Pixel 15-i carries the opposite entry of pixel i for odd k,
    // so the fold difference covers both
    always_comb begin
        for (int j = 0; j < HALF_POINTS; j++) begin
            odd_nxt[j] = '0;
            for (int i = 0; i < HALF_POINTS; i++) begin
                // Sign extension of the difference lane
                odd_nxt[j] = odd_nxt[j]
                           + acc_t'(fold_diff[i]) * odd_entry(2 * j + 1, i);
            end
        end
    end

    // Second pipeline register, odd half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < HALF_POINTS; j++) begin
                odd_acc[j] <= '0;
            end
        end else begin
            for (int j = 0; j < HALF_POINTS; j++) begin
                odd_acc[j] <= odd_nxt[j];
            end
        end
    end

endmodule

/* src/dct_output_round.sv */
// Floor shift by OUT_SHIFT then wraps to 11 bits; large shifts only coarsen the scale
`timescale 1ns/1ns

module dct_output_round import dct_pkg::*; #(
    parameter int OUT_SHIFT = 7
) (
    input  logic     clk,
    input  logic     rst_n,
    input  acc_t     even_acc [HALF_POINTS],
    input  acc_t     odd_acc  [HALF_POINTS],
    output row_out_t x_k_out
);

    // Scaled accumulators, still at full width
    acc_t     even_shf [HALF_POINTS];
    acc_t     odd_shf  [HALF_POINTS];

    row_out_t row_nxt;

    always_comb begin
        row_nxt = '0;
        for (int j = 0; j < HALF_POINTS; j++) begin
            // Arithmetic shift gives floor for negative sums
            even_shf[j] = even_acc[j] >>> OUT_SHIFT;
            odd_shf[j]  = odd_acc[j] >>> OUT_SHIFT;

            // Interleave back into natural order, coefficient 0 on top
            row_nxt[(N_POINTS-1-2*j)*OUT_W +: OUT_W] = coef_out_t'(even_shf[j]);
            row_nxt[(N_POINTS-2-2*j)*OUT_W +: OUT_W] = coef_out_t'(odd_shf[j]);
        end
    end

    // Third pipeline register drives the output row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_k_out <= '0;
        end else begin
            x_k_out <= row_nxt;
        end
    end

endmodule

/* src/dct_1d_row.sv */
// No handshake, a row enters every clock and leaves three clocks later; output is zero in reset
`timescale 1ns/1ns

module dct_1d_row import dct_pkg::*; #(
    parameter int OUT_SHIFT = 7
) (
    input  logic     clk,
    input  logic     rst_n,
    input  row_in_t  x_n_in,
    output row_out_t x_k_out
);

    // Stage 1 to stage 2
    fold_t fold_sum  [HALF_POINTS];
    fold_t fold_diff [HALF_POINTS];

    // Stage 2 to stage 3
    acc_t  even_acc  [HALF_POINTS];
    acc_t  odd_acc   [HALF_POINTS];

    // Input butterfly
    dct_fold_stage fold_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .x_n_in    (x_n_in),
        .fold_sum  (fold_sum),
        .fold_diff (fold_diff)
    );

    // Even and odd halves run side by side
    dct_even_stage even_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fold_sum (fold_sum),
        .even_acc (even_acc)
    );

    dct_odd_stage odd_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .fold_diff (fold_diff),
        .odd_acc   (odd_acc)
    );

    // Scale, cut and pack
    dct_output_round #(
        .OUT_SHIFT (OUT_SHIFT)
    ) round_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .even_acc (even_acc),
        .odd_acc  (odd_acc),
        .x_k_out  (x_k_out)
    );

endmodule

/* test/dct_ref_model.svh */
// Matrix model built from the cosine index rule; include inside a module that imports dct_pkg
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// Cosine magnitudes C_0 .. C_16 with C_0 = 32
localparam int REF_COEF [17] = '{
    32, 45, 44, 43, 42, 40, 38, 35,
    32, 29, 25, 21, 17, 13, 9, 4,
    0
};

// Signed entry for output k and pixel n
function automatic int ref_entry(input int k, input int n);
    int m;
    m = (k * (2 * n + 1)) % 64;
    // First quarter of the period is positive
    if (m <= 16) begin
        return REF_COEF[m];
    // Second quarter mirrors back toward C_0 with a minus sign
    end else if (m <= 32) begin
        return -REF_COEF[32 - m];
    end else if (m <= 47) begin
        return -REF_COEF[m - 32];
    end else begin
        return REF_COEF[64 - m];
    end
endfunction

// Full matrix product, floor shift and 11-bit cut for one row
function automatic row_out_t ref_row(input row_in_t row, input int shift);
    int       acc;
    int       px;
    int       scaled;
    row_out_t out;
    out = '0;
    for (int k = 0; k < 16; k++) begin
        acc = 0;
        for (int n = 0; n < 16; n++) begin
            // Pixel 0 sits in the top byte
            px  = {24'd0, row[(15 - n) * 8 +: 8]};
            acc = acc + px * ref_entry(k, n);
        end
        // Arithmetic shift of a signed int rounds toward minus infinity
        scaled = acc >>> shift;
        out[(15 - k) * 11 +: 11] = scaled[10:0];
    end
    return out;
endfunction

`endif

/* test/tb_dct_1d_row.sv */
// Checks x_k_out three falling edges after each row is driven; OUT_SHIFT must match the DUT's
`timescale 1ns/1ns

module tb_dct_1d_row import dct_pkg::*; ();

    localparam int OUT_SHIFT = 7;
    localparam int RAND_SEED = 32'h9b58_25e3;

    // Rows driven per test, drain rows are counted separately
    localparam int N_TESTS      = 6;
    localparam int N_RESET      = 3;
    localparam int N_FLAT       = 8;
    localparam int N_IMPULSE    = 16;
    localparam int N_EXTREME    = 4;
    localparam int N_RANDOM     = 200;
    localparam int N_MID_BEFORE = 40;
    localparam int N_MID_HOLD   = 2;
    localparam int N_MID_AFTER  = 40;
    localparam int ROWS_TOTAL   = N_RESET + N_FLAT + N_IMPULSE + N_EXTREME + N_RANDOM
                                + N_MID_BEFORE + N_MID_HOLD + N_MID_AFTER;
    // Three latency cycles per test plus some slack
    localparam int CYCLE_LIMIT  = ROWS_TOTAL + 3 * N_TESTS + 20;

    logic     clk;
    logic     rst_n;
    row_in_t  x_n_in;
    row_out_t x_k_out;

    // Expected rows, oldest at the front
    row_out_t exp_q [$];

    int error_count;
    int check_count;
    int test_errors;
    int test_rows;
    int cycle_count;

    `include "dct_ref_model.svh"

    dct_1d_row #(
        .OUT_SHIFT (OUT_SHIFT)
    ) dct_1d_row_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .x_n_in  (x_n_in),
        .x_k_out (x_k_out)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Run limit in rising edges
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run stopped at %0t ns: cycle limit %0d reached", $time, CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic coef_out_t lane_of(input row_out_t row, input int k);
        return row[(N_POINTS - 1 - k) * OUT_W +: OUT_W];
    endfunction

    function automatic row_in_t random_row();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // One output coefficient against its expected value
    task automatic check_coef(input string name, input coef_out_t got, input coef_out_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input row_out_t got, input row_out_t exp);
        for (int k = 0; k < N_POINTS; k++) begin
            check_coef($sformatf("x_k_out[%0d]", k), lane_of(got, k), lane_of(exp, k));
        end
    endtask

    // At a falling edge: check the row from three edges back, then drive the next one
    task automatic drive_row(input row_in_t row, input logic rst_val);
        row_out_t oldest;
        @(negedge clk);
        oldest = exp_q.pop_front();
        check_row(x_k_out, oldest);
        rst_n  = rst_val;
        x_n_in = row;
        // A row taken while in reset never leaves the pipe
        if (rst_val) begin
            exp_q.push_back(ref_row(row, OUT_SHIFT));
        end else begin
            exp_q.push_back('0);
        end
        test_rows = test_rows + 1;
    endtask

    task automatic start_test();
        test_errors = 0;
        test_rows   = 0;
    endtask

    // Drain the pipe with zero rows so every row of the test is compared
    task automatic end_test(input string name);
        int rows;
        rows = test_rows;
        repeat (3) drive_row('0, 1'b1);
        $display("test %-12s %4d rows, %0d mismatches, %s",
                 name, rows, test_errors, (test_errors == 0) ? "pass" : "FAIL");
    endtask

    // Reset asserted between falling edges, pipe flushed, then traffic resumes
    task automatic reset_mid_stream();
        #10;
        rst_n = 1'b0;
        #5;
        check_row(x_k_out, '0);
        exp_q.delete();
        repeat (3) exp_q.push_back('0);
        repeat (N_MID_HOLD) drive_row('0, 1'b0);
    endtask

    initial begin
        row_in_t row;
        int      flat_vals [N_FLAT];

        clk         = 1'b0;
        rst_n       = 1'b0;
        x_n_in      = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        flat_vals   = '{0, 1, 2, 64, 127, 128, 200, 255};
        void'($urandom(RAND_SEED));
        // Pipe starts full of zero rows, matching the cleared registers
        repeat (3) exp_q.push_back('0);

        // Reset held for three cycles, then zero input
        start_test();
        repeat (N_RESET - 1) drive_row('0, 1'b0);
        drive_row('0, 1'b1);
        end_test("reset");

        // Only coefficient 0 is nonzero, at 4 * v
        start_test();
        foreach (flat_vals[i]) begin
            drive_row({N_POINTS{flat_vals[i][7:0]}}, 1'b1);
        end
        end_test("flat_rows");

        // One column of the matrix per row
        start_test();
        for (int p = 0; p < N_POINTS; p++) begin
            row = '0;
            row[(N_POINTS - 1 - p) * PIXEL_W +: PIXEL_W] = 8'hff;
            drive_row(row, 1'b1);
        end
        end_test("impulses");

        // Alternating and paired patterns with their inverses
        start_test();
        drive_row({8{16'h00ff}}, 1'b1);
        drive_row({8{16'hff00}}, 1'b1);
        drive_row({4{32'h0000_ffff}}, 1'b1);
        drive_row({4{32'hffff_0000}}, 1'b1);
        end_test("extremes");

        // Back to back, three rows in flight
        start_test();
        repeat (N_RANDOM) drive_row(random_row(), 1'b1);
        end_test("random");

        start_test();
        repeat (N_MID_BEFORE) drive_row(random_row(), 1'b1);
        reset_mid_stream();
        repeat (N_MID_AFTER) drive_row(random_row(), 1'b1);
        end_test("mid_reset");

        $display("%0d tests, %0d lane checks, %0d errors", N_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* dct_1d_row.f */
+incdir+test
src/dct_pkg.sv
src/dct_fold_stage.sv
src/dct_even_stage.sv
src/dct_odd_stage.sv
src/dct_output_round.sv
src/dct_1d_row.sv
test/tb_dct_1d_row.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dct_1d_row
FILELIST  = dct_1d_row.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
